// File: tests/ex_stimulus.txt
# pc_next reg1 reg2 imm rs rt rd shamt ex mem wb load  alu zero neg write_reg target store wb_value
# hex; ex={reg_dst,use_shamt,use_imm,alu_op} mem={read,write,branch} wb={reg_write,mem_to_reg}
100 5 7 10 1 2 3 0 40 0 2 0 c 0 0 3 140 7 c
104 dead 2 0 3 1 4 0 41 0 2 0 a 0 0 4 104 2 a
108 0 0 ffffffff 3 4 5 0 42 0 2 0 8 0 0 5 104 a 8
10c 0 30 0 5 6 5 0 43 0 2 0 38 0 0 5 10c 30 38
110 0 f 0 5 1 7 0 44 0 2 0 37 0 0 7 110 f 37
114 0 0 55 0 0 0 0 10 0 2 0 55 0 0 0 268 0 55
118 0 0 0 0 0 8 0 45 0 2 0 ffffffff 0 1 8 118 0 ffffffff
11c 0 0 0 8 0 9 0 46 0 2 0 1 0 0 9 11c 0 1
120 5 80000000 2 a b a 0 46 0 2 0 0 1 0 a 128 80000000 0
124 0 3 0 0 c b 4 67 0 2 0 30 0 0 b 124 3 30
128 0 80000f00 0 0 d c 8 68 0 2 0 80000f 0 0 c 128 80000f00 80000f
12c 0 80000f00 0 0 d d 4 69 0 2 0 f80000f0 0 1 d 12c 80000f00 f80000f0
130 0 0 1234 0 e 0 0 1a 0 2 0 12340000 0 0 e 4a00 0 12340000
134 0 0 8 e f 0 0 10 4 3 cafef00d 12340008 0 0 f 154 0 cafef00d
138 200 77 4 1 e 0 0 10 2 0 0 204 0 0 e 148 12340000 204
13c 0 3 0 f 1 10 0 40 0 2 0 cafef010 0 1 10 13c 3 cafef010
140 0 cafef010 fffffff0 10 11 0 0 01 1 0 0 0 1 0 11 100 cafef010 0
144 0 1 0 10 11 12 0 43 0 2 0 cafef011 0 1 12 144 1 cafef011

// File: sim.f
rtl/ex_pkg.sv
rtl/alu.sv
rtl/forwarding_unit.sv
rtl/execute.sv
rtl/writeback_pipe.sv
rtl/ex_top.sv
tests/ex_checker.sv
tests/tb_ex_top.sv

// File: Bender.yml
package:
  name: ex_stage

sources:
  - rtl/ex_pkg.sv
  - rtl/alu.sv
  - rtl/forwarding_unit.sv
  - rtl/execute.sv
  - rtl/writeback_pipe.sv
  - rtl/ex_top.sv
  - target: test
    files:
      - tests/ex_checker.sv
      - tests/tb_ex_top.sv

// File: tests/tb_ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_top;

	localparam int RESET_CYCLES = 8;
	localparam int PERIOD       = 8; // ns

	typedef logic [31:0] row_t [19]; // one stimulus line, columns as in the file

	logic             clk;
	logic             rst_n;
	ex_pkg::ex_in_t   instr;
	ex_pkg::word_t    load_data;
	ex_pkg::ex_out_t  ex_result;
	logic             wb_reg_write;
	ex_pkg::reg_idx_t wb_write_reg;
	ex_pkg::word_t    wb_value;

	row_t rows[$];
	int   test_err[$];   // mismatches per line
	int   reset_err = 0;
	int   setup_err = 0; // stimulus file unusable
	bit   loaded    = 1'b0;

	ex_top dut_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr        (instr),
		.load_data    (load_data),
		.ex_result    (ex_result),
		.wb_reg_write (wb_reg_write),
		.wb_write_reg (wb_write_reg),
		.wb_value     (wb_value)
	);

	always #(PERIOD / 2) clk = ~clk;

	//////////////////////////////////////////////////
	// helpers

	task automatic compare_value(input string name, input int idx,
		input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("[FAIL] %0t ns  %s  expected %h  actual %h", $time, name, expected, actual);
			if (idx < 0)
				reset_err++; // reset test
			else
				test_err[idx]++;
		end
	endtask

	// file columns 0..10 in field order of the packed instruction
	function automatic ex_pkg::ex_in_t to_instr(input row_t r);
		return {r[0], r[1], r[2], r[3], r[4][4:0], r[5][4:0], r[6][4:0], r[7][4:0],
			r[8][6:0], r[9][2:0], r[10][1:0]};
	endfunction

	task automatic read_stimulus(input int fd);
		string line;
		row_t  r;
		while ($fgets(line, fd) != 0)
		begin
			if (line.len() > 1 && line[0] != "#") // header and blank lines skipped
			begin
				if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					r[0], r[1], r[2], r[3], r[4], r[5], r[6], r[7], r[8], r[9],
					r[10], r[11], r[12], r[13], r[14], r[15], r[16], r[17], r[18]) != 19)
				begin
					$display("stimulus line could not be parsed: %s", line);
					setup_err++;
				end
				else
				begin
					rows.push_back(r);
					test_err.push_back(0);
				end
			end
		end
	endtask

	// 3/4 register, mem and wb control pass straight through
	task automatic verify_execute(input int idx);
		row_t r;
		r = rows[idx];
		compare_value("ex_result.alu_result", idx, r[12], ex_result.alu_result);
		compare_value("ex_result.zero", idx, r[13], ex_result.zero);
		compare_value("ex_result.neg", idx, r[14], ex_result.neg);
		compare_value("ex_result.write_reg", idx, r[15], ex_result.write_reg);
		compare_value("ex_result.branch_target", idx, r[16], ex_result.branch_target);
		compare_value("ex_result.store_data", idx, r[17], ex_result.store_data);
		compare_value("ex_result.mem", idx, r[9], ex_result.mem);
		compare_value("ex_result.wb", idx, r[10], ex_result.wb);
	endtask

	// stage 5, two cycles after the drive
	task automatic finish_test(input int idx);
		compare_value("wb_value", idx, rows[idx][18], wb_value);
		compare_value("wb_write_reg", idx, rows[idx][15], wb_write_reg);
		compare_value("wb_reg_write", idx, rows[idx][10][1], wb_reg_write);
		$display("test %0d: %s", idx, (test_err[idx] == 0) ? "ok" : "mismatch");
	endtask

	//////////////////////////////////////////////////
	// main sequence
	initial
	begin
		int fd;
		int failed;
		int total_err;
		clk       = 1'b0;
		rst_n     = 1'b0;
		instr     = '0;
		load_data = '0;
		fd = $fopen("tests/ex_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("could not open tests/ex_stimulus.txt");
			setup_err++;
		end
		else
		begin
			read_stimulus(fd);
			$fclose(fd);
			if (rows.size() == 0)
			begin
				$display("no stimulus lines found in tests/ex_stimulus.txt");
				setup_err++;
			end
			loaded = (rows.size() > 0);
		end
		if (loaded)
		begin
			repeat (RESET_CYCLES - 1) @(posedge clk);
			@(negedge clk); // still in reset
			compare_value("ex_result.mem", -1, 0, ex_result.mem);
			compare_value("ex_result.wb", -1, 0, ex_result.wb);
			compare_value("ex_result.alu_result", -1, 0, ex_result.alu_result);
			compare_value("wb_reg_write", -1, 0, wb_reg_write);
			compare_value("wb_value", -1, 0, wb_value);
			$display("test reset: %s", (reset_err == 0) ? "ok" : "mismatch");
			@(posedge clk);
			rst_n <= 1'b1; // released on the 8th edge
			for (int j = 0; j < rows.size() + 2; j++)
			begin
				@(posedge clk);
				instr     <= (j < rows.size()) ? to_instr(rows[j]) : '0; // two bubbles flush
				load_data <= (j > 0 && j <= rows.size()) ? rows[j - 1][11] : '0; // load in stage 4
				@(negedge clk);
				if (j >= 1 && j <= rows.size())
					verify_execute(j - 1);
				if (j >= 2)
					finish_test(j - 2);
			end
		end
		total_err = reset_err + setup_err;
		failed    = (reset_err != 0) ? 1 : 0;
		foreach (test_err[i])
		begin
			total_err += test_err[i];
			if (test_err[i] != 0)
				failed++;
		end
		$display("summary: %0d tests, %0d failed, %0d mismatches, %0d setup errors",
			loaded ? rows.size() + 1 : 0, failed, total_err - setup_err, setup_err);
		if (total_err == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// watchdog, sized from the number of lines
	initial
	begin
		wait (loaded);
		#((rows.size() + RESET_CYCLES + 10) * PERIOD);
		$display("timeout: the run did not finish in the expected number of cycles");
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/ex_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ex_checker (
	input logic             clk,
	input logic             rst_n,
	input ex_pkg::ex_out_t  ex_result,
	input logic             wb_reg_write,
	input ex_pkg::reg_idx_t wb_write_reg
);

	//////////////////////////////////////////////////
	// no control leaks out while in reset
	reset_clears_control: assert property (@(posedge clk)
		!rst_n |-> (ex_result.mem == '0 && ex_result.wb == '0 && !wb_reg_write))
		else $error("control outputs not cleared during reset");

	// stage 5 reg_write is stage 4 one edge later
	wb_follows_stage4: assert property (@(posedge clk) disable iff (!rst_n)
		wb_reg_write == $past(ex_result.wb.reg_write))
		else $error("wb_reg_write does not follow ex_result.wb.reg_write");

	wb_reg_known: assert property (@(posedge clk) disable iff (!rst_n)
		wb_reg_write |-> !$isunknown(wb_write_reg))
		else $error("wb_write_reg unknown while wb_reg_write is set");

endmodule

bind ex_top ex_checker u_ex_checker (
	.clk          (clk),
	.rst_n        (rst_n),
	.ex_result    (ex_result),
	.wb_reg_write (wb_reg_write),
	.wb_write_reg (wb_write_reg)
);

`default_nettype wire

// File: rtl/ex_top.sv
`timescale 1ns/1ps
`default_nettype none

module ex_top (
	input  logic             clk,
	input  logic             rst_n,
	input  ex_pkg::ex_in_t   instr,
	input  ex_pkg::word_t    load_data,    // for the load now in stage 4
	output ex_pkg::ex_out_t  ex_result,    // 3/4 register
	output logic             wb_reg_write, // stage 5, two cycles after instr
	output ex_pkg::reg_idx_t wb_write_reg,
	output ex_pkg::word_t    wb_value
);

	ex_pkg::fwd_src_t fwd_mem;
	ex_pkg::fwd_src_t fwd_wb;

	//////////////////////////////////////////////////
	// execute stage plus its forwarding loop
	execute u_execute (
		.clk       (clk),
		.rst_n     (rst_n),
		.instr     (instr),
		.fwd_mem   (fwd_mem),
		.fwd_wb    (fwd_wb),
		.ex_result (ex_result)
	);

	writeback_pipe u_writeback_pipe (
		.clk       (clk),
		.rst_n     (rst_n),
		.ex_result (ex_result),
		.load_data (load_data),
		.fwd_mem   (fwd_mem),
		.fwd_wb    (fwd_wb)
	);

	// stage 5 seen from outside
	assign wb_reg_write = fwd_wb.reg_write;
	assign wb_write_reg = fwd_wb.write_reg;
	assign wb_value     = fwd_wb.value;

endmodule

`default_nettype wire

// File: rtl/writeback_pipe.sv
`timescale 1ns/1ps
`default_nettype none

// stand-in for the memory and writeback stages
module writeback_pipe (
	input  logic             clk,
	input  logic             rst_n,
	input  ex_pkg::ex_out_t  ex_result, // stage 4 contents
	input  ex_pkg::word_t    load_data, // valid while stage 4 holds the load
	output ex_pkg::fwd_src_t fwd_mem,
	output ex_pkg::fwd_src_t fwd_wb
);

	logic             wb_reg_write; // stage 5 registers
	ex_pkg::reg_idx_t wb_write_reg;
	ex_pkg::word_t    wb_value;
	ex_pkg::word_t    wb_next;      // load or alu, chosen in stage 4

	//////////////////////////////////////////////////
	// stage 4 feedback, straight from the 3/4 register
	assign fwd_mem.reg_write = ex_result.wb.reg_write;
	assign fwd_mem.write_reg = ex_result.write_reg;
	assign fwd_mem.value     = ex_result.alu_result; // never the load value

	assign wb_next = ex_result.wb.mem_to_reg ? load_data : ex_result.alu_result;

	// stage 4/5 register
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wb_reg_write <= 1'b0;
			wb_write_reg <= '0;
			wb_value     <= '0;
		end
		else
		begin
			wb_reg_write <= ex_result.wb.reg_write;
			wb_write_reg <= ex_result.write_reg;
			wb_value     <= wb_next;
		end
	end

	// stage 5 feedback, final value
	assign fwd_wb.reg_write = wb_reg_write;
	assign fwd_wb.write_reg = wb_write_reg;
	assign fwd_wb.value     = wb_value;

endmodule

`default_nettype wire

// File: rtl/execute.sv
`timescale 1ns/1ps
`default_nettype none

module execute (
	input  logic             clk,
	input  logic             rst_n,
	input  ex_pkg::ex_in_t   instr,   // from decode
	input  ex_pkg::fwd_src_t fwd_mem, // stage 4 feedback
	input  ex_pkg::fwd_src_t fwd_wb,  // stage 5 feedback
	output ex_pkg::ex_out_t  ex_result
);

	ex_pkg::fwd_sel_e sel_a;
	ex_pkg::fwd_sel_e sel_b;
	ex_pkg::word_t    fwd_a;   // reg1 after forwarding
	ex_pkg::word_t    fwd_b;   // reg2 after forwarding
	ex_pkg::word_t    op_a;
	ex_pkg::word_t    op_b;
	ex_pkg::word_t    alu_out;
	logic             alu_zero;
	logic             alu_neg;
	ex_pkg::ex_out_t  ex_next; // value for the 3/4 register

	// one forwarding mux, used for both operands
	function automatic ex_pkg::word_t fwd_mux(
		input ex_pkg::fwd_sel_e sel,
		input ex_pkg::word_t    reg_val,
		input ex_pkg::word_t    mem_val,
		input ex_pkg::word_t    wb_val
	);
		case (sel)
			ex_pkg::FWD_MEM:
				fwd_mux = mem_val;
			ex_pkg::FWD_WB:
				fwd_mux = wb_val;
			default:
				fwd_mux = reg_val; // FWD_REG
		endcase
	endfunction

	//////////////////////////////////////////////////
	// operand selection
	forwarding_unit u_forwarding_unit (
		.rs      (instr.rs),
		.rt      (instr.rt),
		.fwd_mem (fwd_mem),
		.fwd_wb  (fwd_wb),
		.sel_a   (sel_a),
		.sel_b   (sel_b)
	);

	assign fwd_a = fwd_mux(sel_a, instr.reg1, fwd_mem.value, fwd_wb.value);
	assign fwd_b = fwd_mux(sel_b, instr.reg2, fwd_mem.value, fwd_wb.value);

	// shamt and immediate take over after forwarding
	assign op_a = instr.ex.use_shamt ? ex_pkg::word_t'(instr.shamt) : fwd_a; // zero extended
	assign op_b = instr.ex.use_imm ? instr.imm : fwd_b;

	alu u_alu (
		.a      (op_a),
		.b      (op_b),
		.op     (instr.ex.alu_op),
		.result (alu_out),
		.zero   (alu_zero),
		.neg    (alu_neg)
	);

	//////////////////////////////////////////////////
	// next contents of the 3/4 register
	always_comb
	begin
		ex_next.branch_target = instr.pc_next + (instr.imm << 2); // word offset
		ex_next.alu_result    = alu_out;
		ex_next.store_data    = fwd_b; // sw needs the fresh value too
		ex_next.zero          = alu_zero;
		ex_next.neg           = alu_neg;
		ex_next.write_reg     = instr.ex.reg_dst ? instr.rd : instr.rt; // r-type vs i-type
		ex_next.mem           = instr.mem; // pass through
		ex_next.wb            = instr.wb;
	end

	// stage 3/4 register
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ex_result <= '0; // control and data fields cleared
		end
		else
		begin
			ex_result <= ex_next;
		end
	end

endmodule

`default_nettype wire

// File: rtl/forwarding_unit.sv
`timescale 1ns/1ps
`default_nettype none

module forwarding_unit (
	input  ex_pkg::reg_idx_t rs,      // source of operand a
	input  ex_pkg::reg_idx_t rt,      // source of operand b
	input  ex_pkg::fwd_src_t fwd_mem, // stage 4
	input  ex_pkg::fwd_src_t fwd_wb,  // stage 5
	output ex_pkg::fwd_sel_e sel_a,
	output ex_pkg::fwd_sel_e sel_b
);

	// true when a later stage will write this source register
	function automatic logic hits(input ex_pkg::fwd_src_t src, input ex_pkg::reg_idx_t r);
		hits = src.reg_write && (src.write_reg != '0) && (src.write_reg == r);
	endfunction

	// stage 4 is newer, so it wins over stage 5
	function automatic ex_pkg::fwd_sel_e pick(
		input ex_pkg::reg_idx_t r,
		input ex_pkg::fwd_src_t mem_src,
		input ex_pkg::fwd_src_t wb_src
	);
		if (hits(mem_src, r))
			pick = ex_pkg::FWD_MEM;
		else if (hits(wb_src, r))
			pick = ex_pkg::FWD_WB;
		else
			pick = ex_pkg::FWD_REG; // $zero lands here too
	endfunction

	////////////////////////////////////////////////////
	// one select per operand
	assign sel_a = pick(rs, fwd_mem, fwd_wb);
	assign sel_b = pick(rt, fwd_mem, fwd_wb);

endmodule

`default_nettype wire

// File: rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

// plain combinational alu, no pipeline register inside
module alu (
	input  ex_pkg::word_t   a,   // shift amount for shifts
	input  ex_pkg::word_t   b,   // shifted value for shifts
	input  ex_pkg::alu_op_e op,
	output ex_pkg::word_t   result,
	output logic            zero,
	output logic            neg
);

	logic [4:0] shamt; // only low five bits count for shifts

	assign shamt = a[4:0];

	always_comb
	begin
		case (op)
			ex_pkg::ADD:
				result = a + b;
			ex_pkg::SUB:
				result = a - b;
			ex_pkg::AND:
				result = a & b;
			ex_pkg::OR:
				result = a | b;
			ex_pkg::XOR:
				result = a ^ b;
			ex_pkg::NOR:
				result = ~(a | b);
			ex_pkg::SLT: // signed compare
				result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ex_pkg::SLL:
				result = b << shamt;
			ex_pkg::SRL:
				result = b >> shamt;
			ex_pkg::SRA: // keep sign bit
				result = ex_pkg::word_t'($signed(b) >>> shamt);
			ex_pkg::LUI:
				result = b << 16; // imm into upper half
			default:
				result = '0; // unknown code
		endcase
	end

	// flags straight off the result
	assign zero = (result == '0);
	assign neg  = result[31];

endmodule

`default_nettype wire

// File: rtl/ex_pkg.sv
`default_nettype none

package ex_pkg;

	//////////////////////////////////////////////////
	// widths with a meaning
	typedef logic [31:0] word_t;    // data word or address
	typedef logic [4:0]  reg_idx_t; // register number, 32 regs

	// alu operation codes
	typedef enum logic [3:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		AND = 4'd2,
		OR  = 4'd3,
		XOR = 4'd4,
		NOR = 4'd5,
		SLT = 4'd6,  // signed compare
		SLL = 4'd7,
		SRL = 4'd8,
		SRA = 4'd9,
		LUI = 4'd10
	} alu_op_e;

	// operand source picked by the forwarding unit
	typedef enum logic [1:0] {
		FWD_REG = 2'd0, // register file value
		FWD_MEM = 2'd1, // stage 4 alu result
		FWD_WB  = 2'd2  // stage 5 final value
	} fwd_sel_e;

	//////////////////////////////////////////////////
	// control buses carried down the pipe
	typedef struct packed {
		logic    reg_dst;   // rd instead of rt
		logic    use_shamt; // operand a = shamt
		logic    use_imm;   // operand b = imm
		alu_op_e alu_op;
	} ex_ctrl_t;

	typedef struct packed {
		logic mem_read;
		logic mem_write;
		logic branch;
	} mem_ctrl_t;

	typedef struct packed {
		logic reg_write;
		logic mem_to_reg; // load data instead of alu result
	} wb_ctrl_t;

	// one issued instruction, as it leaves decode
	typedef struct packed {
		word_t     pc_next;
		word_t     reg1;
		word_t     reg2;
		word_t     imm;     // already sign extended
		reg_idx_t  rs;
		reg_idx_t  rt;
		reg_idx_t  rd;
		reg_idx_t  shamt;
		ex_ctrl_t  ex;
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
	} ex_in_t;

	// stage 3/4 register contents
	typedef struct packed {
		word_t     branch_target;
		word_t     alu_result;
		word_t     store_data; // forwarded reg2
		logic      zero;
		logic      neg;
		reg_idx_t  write_reg;
		mem_ctrl_t mem;
		wb_ctrl_t  wb;
	} ex_out_t;

	// one forwarding source, stage 4 or stage 5
	typedef struct packed {
		logic     reg_write;
		reg_idx_t write_reg;
		word_t    value;
	} fwd_src_t;

endpackage

`default_nettype wire
